// File: vlog.f
hdl/vid_pkg.sv
hdl/bus_regs.sv
hdl/video_timing.sv
hdl/pixel_gen.sv
hdl/vid_top.sv
verif/tb_vid_top.sv

// File: Makefile
# Verilator build for the video controller testbench
# make compile builds the model, make run simulates and checks the log

SIM = obj_dir/Vtb_vid_top
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): vlog.f hdl/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vid_top -f vlog.f

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_vid_top.sv
/*
 * testbench for the video controller: resets the core, exercises the host
 * registers over the byte bus, then watches raster, pattern and status over three frames
 */
`default_nettype none
`timescale 1ns/1ps

module tb_vid_top;
    import vid_pkg::*;

    localparam int H_ACTIVE     = 32;
    localparam int H_FRONT      = 4;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 8;
    localparam int V_ACTIVE     = 16;
    localparam int V_FRONT      = 2;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 4;
    localparam int RESET_DELAY  = 4;
    localparam int LINE_CYCLES  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;          // 48
    localparam int FRAME_CYCLES = LINE_CYCLES * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    // reset, bus phase, wait for first vsync, then three checked frames
    localparam int MAX_CYCLES   = 8 + RESET_DELAY + 400 + 4 * FRAME_CYCLES;

    localparam int T_RESET   = 0;                   // test index into the counters
    localparam int T_REGS    = 1;
    localparam int T_TIMING  = 2;
    localparam int T_PATTERN = 3;
    localparam int T_STATUS  = 4;

    logic       pclk = 1'b0;
    logic       rst_i;
    bus_t       bus;                                // host bus driven on negedge
    logic [7:0] bus_data;
    logic       bus_oe;
    video_t     video;

    int    seed = 32'h806c_9f6b;
    int    err_cnt [5] = '{0, 0, 0, 0, 0};
    int    chk_cnt [5] = '{0, 0, 0, 0, 0};
    string test_name [5] = '{"reset_quiet", "register_access", "raster_timing",
                             "pattern_output", "status_read"};
    int    rst_edges = 0;                           // edges since rst_i fell
    logic [1:0] seen_edge = 2'b00;                  // high bit set once reset reached the flops
    logic  quiet;                                   // core still held in reset
    int    cycles = 0;

    video_t    v;                                   // monitor copy of video
    video_t    prev_v;
    int        tb_x, tb_y;                          // own raster position
    int        since_hs, hs_len, de_len, vs_len, de_lines, hs_rises;
    logic      vs_rise_now;
    event      pix_sampled;                         // monitor done for this cycle
    rgb_t      exp_fg, exp_bg;                      // shadow of written registers
    pat_mode_e exp_mode;
    logic      pat_check_en = 1'b0;

    vid_top #(
        .H_ACTIVE    (H_ACTIVE),
        .H_FRONT     (H_FRONT),
        .H_SYNC      (H_SYNC),
        .H_BACK      (H_BACK),
        .V_ACTIVE    (V_ACTIVE),
        .V_FRONT     (V_FRONT),
        .V_SYNC      (V_SYNC),
        .V_BACK      (V_BACK),
        .RESET_DELAY (RESET_DELAY)
    ) vid_top_i (
        .pclk       (pclk),
        .rst_i      (rst_i),
        .bus_i      (bus),
        .bus_data_o (bus_data),
        .bus_oe_o   (bus_oe),
        .video_o    (video)
    );

    initial begin
        forever #50 pclk = ~pclk;                   // 100 ns period
    end

    always @(posedge pclk) begin
        seen_edge <= {seen_edge[0], 1'b1};
        if (rst_i) begin
            rst_edges <= 0;
        end else if (rst_edges <= RESET_DELAY + 1) begin
            rst_edges <= rst_edges + 1;             // saturates once core is out
        end
    end

    assign quiet = rst_i || (rst_edges <= RESET_DELAY);

    task automatic check_eq(input int t, input logic [31:0] exp_v, input logic [31:0] act_v);
        chk_cnt[t]++;
        assert (act_v === exp_v) else begin
            err_cnt[t]++;
            $display("FAILED %s expected %0h actual %0h at %0t",
                     test_name[t], exp_v, act_v, $time);
        end
    endtask

    // blank video and no bus drive while the core sits in reset
    assert property (@(posedge pclk) (seen_edge[1] && quiet) |-> (video == '0 && !bus_oe))
        else begin
            err_cnt[T_RESET]++;
            $display("FAILED reset_quiet expected 0 actual %h",
                     {$sampled(bus_oe), $sampled(video)});
        end

    assert property (@(posedge pclk)
        (seen_edge[1] && !quiet) |-> (bus_oe == (!bus.cs_n && bus.rd_nwr)))
        else begin
            err_cnt[T_REGS]++;
            $display("FAILED register_access expected oe %b actual %b",
                     !$sampled(bus.cs_n) && $sampled(bus.rd_nwr), $sampled(bus_oe));
        end

    assert property (@(posedge pclk) (seen_edge[1] && !video.de) |-> (video.rgb == '0))
        else begin
            err_cnt[T_PATTERN]++;
            $display("FAILED pattern_output expected 000 actual %h", $sampled(video.rgb));
        end

    function automatic logic [15:0] field_mask(input reg_num_e slot);
        case (slot)
            REG_FG, REG_BG: return 16'h0fff;        // 12-bit colour
            REG_MODE:       return 16'h0003;
            REG_SCRATCH:    return 16'hffff;
            default:        return 16'h0000;        // status is read only and spares are empty
        endcase
    endfunction

    function automatic rgb_t expected_pixel(input int x, input int y);
        logic fg_sel;
        case (exp_mode)
            PAT_BARS:  fg_sel = x[3];
            PAT_CHECK: fg_sel = x[3] ^ y[3];
            default:   fg_sel = 1'b1;
        endcase
        return fg_sel ? exp_fg : exp_bg;
    endfunction

    // raster model rebuilt from the observed syncs and display enable
    always @(negedge pclk) begin
        v = video;
        vs_rise_now = 1'b0;
        if (quiet) begin
            prev_v   = '0;
            tb_x     = 0;
            tb_y     = -1;
            since_hs = 0;
            hs_len   = 0;
            de_len   = 0;
            vs_len   = 0;
            de_lines = 0;
            hs_rises = 0;
        end else begin
            if (v.de && !prev_v.de) begin       // new active line
                tb_x = 0;
                tb_y = tb_y + 1;
                de_lines++;
            end else if (v.de) begin
                tb_x++;
            end
            if (v.hs && !prev_v.hs) begin
                if (hs_rises > 0) check_eq(T_TIMING, LINE_CYCLES, since_hs);
                since_hs = 0;
                hs_rises++;
            end
            since_hs++;
            if (!v.hs && prev_v.hs) begin
                check_eq(T_TIMING, H_SYNC, hs_len);
                hs_len = 0;
            end
            if (!v.de && prev_v.de) begin
                check_eq(T_TIMING, H_ACTIVE, de_len);
                de_len = 0;
            end
            if (!v.vs && prev_v.vs) begin
                check_eq(T_TIMING, V_SYNC * LINE_CYCLES, vs_len);
                vs_len = 0;
            end
            if (v.vs && !prev_v.vs) begin       // frame boundary
                check_eq(T_TIMING, V_ACTIVE, de_lines);
                de_lines    = 0;
                tb_y        = -1;
                vs_rise_now = 1'b1;
            end
            if (v.hs) hs_len++;
            if (v.de) de_len++;
            if (v.vs) vs_len++;
            if (pat_check_en && v.de) begin
                check_eq(T_PATTERN, {20'h0, expected_pixel(tb_x, tb_y)}, {20'h0, v.rgb});
            end
            prev_v = v;
        end
        -> pix_sampled;
    end

    task automatic bus_write(input reg_num_e slot, input logic [15:0] word);
        @(negedge pclk);
        bus = '{cs_n: 1'b0, rd_nwr: 1'b0, bytesel: 1'b0, reg_num: slot, data: word[15:8]};
        @(negedge pclk);
        bus.bytesel = 1'b1;                         // odd byte carries the low half
        bus.data    = word[7:0];
        @(negedge pclk);
        bus.cs_n    = 1'b1;
        bus.rd_nwr  = 1'b1;
    endtask

    task automatic bus_read(input reg_num_e slot, output logic [15:0] word);
        @(negedge pclk);
        bus = '{cs_n: 1'b0, rd_nwr: 1'b1, bytesel: 1'b0, reg_num: slot, data: 8'h00};
        @(negedge pclk);
        word[15:8]  = bus_data;                     // registered one edge after select
        bus.bytesel = 1'b1;
        @(negedge pclk);
        word[7:0]   = bus_data;
        bus.cs_n    = 1'b1;
    endtask

    task automatic wait_vs_rise();
        do @(pix_sampled); while (!vs_rise_now);
    endtask

    task automatic wait_de_pixel(input int x);
        do @(pix_sampled); while (!(prev_v.de && tb_x == x));
    endtask

    initial begin
        logic [15:0] word;
        logic [15:0] written [4];
        reg_num_e    slot;
        rgb_t        fg;
        rgb_t        bg;
        int          exp_y;
        int          total;
        rst_i = 1'b1;
        bus   = '{cs_n: 1'b0, rd_nwr: 1'b0, bytesel: 1'b1, reg_num: REG_FG, data: 8'hff};
        for (int i = 0; i < 8; i++) begin           // writes to fg, bg and mode during reset
            bus.reg_num = reg_num_e'(i % 3);
            @(negedge pclk);
        end
        rst_i      = 1'b0;
        bus.rd_nwr = 1'b1;                          // selected read while the delay runs
        repeat (RESET_DELAY + 2) @(negedge pclk);
        bus.cs_n   = 1'b1;
        for (int i = 0; i < 3; i++) begin           // fg, bg and mode come up cleared
            bus_read(reg_num_e'(i), word);
            check_eq(T_RESET, 0, {16'h0, word});
        end

        // random words all written before any read back
        for (int i = 0; i < 4; i++) begin
            slot = reg_num_e'(i);
            word = 16'($random(seed));
            bus_write(slot, word);
            written[i] = word & field_mask(slot);
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(reg_num_e'(i), word);
            check_eq(T_REGS, {16'h0, written[i]}, {16'h0, word});
        end
        slot = reg_num_e'(4'd9);                    // spare slot
        bus_write(slot, 16'hffff);
        bus_read(slot, word);
        check_eq(T_REGS, {16'h0, 16'hffff & field_mask(slot)}, {16'h0, word});

        // one full frame per mode with registers changed inside vertical blank
        for (int m = 0; m < 3; m++) begin
            wait_vs_rise();
            pat_check_en = 1'b0;
            bus_read(REG_STATUS, word);
            check_eq(T_STATUS, 1, {31'h0, word[15]});
            fg = 12'($random(seed));
            bg = 12'($random(seed));
            if (bg == fg) bg = ~fg;
            bus_write(REG_FG, {4'h0, fg});
            bus_write(REG_BG, {4'h0, bg});
            bus_write(REG_MODE, {14'h0, 2'(m)});
            repeat (3) @(negedge pclk);             // still in blanking
            exp_fg       = fg;
            exp_bg       = bg;
            exp_mode     = pat_mode_e'(m);
            pat_check_en = 1'b1;
            wait_de_pixel(8);
            exp_y = tb_y;
            bus_read(REG_STATUS, word);
            check_eq(T_STATUS, 0, {31'h0, word[15]});
            check_eq(T_STATUS, exp_y, {22'h0, word[9:0]});
        end
        wait_vs_rise();
        pat_check_en = 1'b0;

        total = 0;
        for (int t = 0; t < 5; t++) begin
            if (chk_cnt[t] == 0) begin
                $display("no %s checks were reached", test_name[t]);
                err_cnt[t]++;
            end
            total += err_cnt[t];
        end
        $display("errors: reset_quiet %0d register_access %0d raster_timing %0d %s %0d %s %0d",
                 err_cnt[T_RESET], err_cnt[T_REGS], err_cnt[T_TIMING],
                 "pattern_output", err_cnt[T_PATTERN], "status_read", err_cnt[T_STATUS]);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge pclk);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", MAX_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/vid_top.sv
/*
 * video controller top: power-on reset delay, host register block,
 * raster timing and pixel stage; timing parameters are set here and passed down
 */
`default_nettype none
`timescale 1ns/1ps

module vid_top #(
    parameter int H_ACTIVE    = 640,                // 640x480 at 60 Hz defaults
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33,
    parameter int RESET_DELAY = 255                 // edges of extra reset after rst_i
) (
    input  logic             pclk,                  // pixel clock
    input  logic             rst_i,                 // external reset, sync, active high
    input  vid_pkg::bus_t    bus_i,                 // host bus levels
    output logic [7:0]       bus_data_o,            // read data to host
    output logic             bus_oe_o,              // drive enable for host data bus
    output vid_pkg::video_t  video_o                // rgb with syncs
);
    import vid_pkg::*;

    localparam int CNT_W = $clog2(RESET_DELAY + 1) + 1;
    localparam logic [CNT_W-1:0] DELAY_LAST = CNT_W'(RESET_DELAY);

    logic [CNT_W-1:0] rst_cnt_q;                    // edges since rst_i fell
    logic             sys_rst;                      // reset for the whole core
    ctrl_regs_t       regs;                         // bus_regs to pixel_gen
    timing_t          raster;                       // timing to pixel_gen and status

    // hold the core in reset a fixed number of edges after rst_i drops
    always_ff @(posedge pclk) begin
        if (rst_i) begin
            rst_cnt_q <= '0;
            sys_rst   <= 1'b1;
        end else if (rst_cnt_q != DELAY_LAST) begin
            rst_cnt_q <= rst_cnt_q + 1'b1;          // still counting, stay in reset
            sys_rst   <= 1'b1;
        end else begin
            sys_rst   <= 1'b0;                      // counter parks at the last value
        end
    end

    bus_regs #(
        .V_ACTIVE   (V_ACTIVE)
    ) bus_regs_i (
        .pclk       (pclk),
        .rst_i      (sys_rst),
        .bus_i      (bus_i),
        .raster_i   (raster),
        .regs_o     (regs),
        .bus_data_o (bus_data_o),
        .bus_oe_o   (bus_oe_o)
    );

    video_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) video_timing_i (
        .pclk     (pclk),
        .rst_i    (sys_rst),
        .raster_o (raster)
    );

    pixel_gen pixel_gen_i (
        .pclk     (pclk),
        .rst_i    (sys_rst),
        .raster_i (raster),
        .regs_i   (regs),
        .video_o  (video_o)
    );

endmodule

`default_nettype wire

// File: hdl/pixel_gen.sv
/*
 * pixel stage: picks fg or bg by pattern mode from x and y bits and registers
 * colour with de, hs and vs, one cycle of latency and a new pixel every cycle
 */
`default_nettype none
`timescale 1ns/1ps

module pixel_gen (
    input  logic                pclk,
    input  logic                rst_i,              // sync, active high
    input  vid_pkg::timing_t    raster_i,           // position and sync for this cycle
    input  vid_pkg::ctrl_regs_t regs_i,             // colours and mode
    output vid_pkg::video_t     video_o             // registered video
);
    import vid_pkg::*;

    logic   use_fg;                                 // pattern picks foreground
    rgb_t   colour;                                 // before blanking
    rgb_t   pixel;                                  // after blanking
    video_t video_q;

    always_comb begin
        case (regs_i.mode)
            PAT_SOLID: use_fg = 1'b1;
            PAT_BARS:  use_fg = raster_i.x[3];                      // 8 pixel wide bars
            PAT_CHECK: use_fg = raster_i.x[3] ^ raster_i.y[3];      // 8x8 checker
            default:   use_fg = 1'b1;                               // spare code acts solid
        endcase
    end

    assign colour = use_fg ? regs_i.fg : regs_i.bg;
    assign pixel  = raster_i.de ? colour : '0;      // black in porches and sync

    // syncs go through the same flop as colour so they stay aligned
    always_ff @(posedge pclk) begin
        if (rst_i) begin
            video_q <= '0;
        end else begin
            video_q.de  <= raster_i.de;
            video_q.hs  <= raster_i.hs;
            video_q.vs  <= raster_i.vs;
            video_q.rgb <= pixel;
        end
    end

    assign video_o = video_q;

endmodule

`default_nettype wire

// File: hdl/video_timing.sv
/*
 * raster timing generator: wrapping pixel and line counters compared against
 * the porch and sync parameters give position, hsync, vsync and display enable
 */
`default_nettype none
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 640,                   // visible pixels per line
    parameter int H_FRONT  = 16,                    // front porch, pixels
    parameter int H_SYNC   = 96,                    // hsync width, pixels
    parameter int H_BACK   = 48,                    // back porch, pixels
    parameter int V_ACTIVE = 480,                   // visible lines per frame
    parameter int V_FRONT  = 10,                    // front porch, lines
    parameter int V_SYNC   = 2,                     // vsync width, lines
    parameter int V_BACK   = 33                     // back porch, lines
) (
    input  logic             pclk,
    input  logic             rst_i,                 // sync, active high
    output vid_pkg::timing_t raster_o               // raster state for this cycle
);
    import vid_pkg::*;

    // compare points, 10 bits covers totals up to 1024
    localparam logic [9:0] H_ACT    = 10'(H_ACTIVE);
    localparam logic [9:0] HS_START = 10'(H_ACTIVE + H_FRONT);
    localparam logic [9:0] HS_END   = 10'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [9:0] H_LAST   = 10'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [9:0] V_ACT    = 10'(V_ACTIVE);
    localparam logic [9:0] VS_START = 10'(V_ACTIVE + V_FRONT);
    localparam logic [9:0] VS_END   = 10'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam logic [9:0] V_LAST   = 10'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    logic [9:0] x_q;                                // pixel counter
    logic [9:0] y_q;                                // line counter
    logic       x_wrap;                             // last pixel of line
    logic       y_wrap;                             // last line of frame
    timing_t    raster;

    assign x_wrap = (x_q == H_LAST);
    assign y_wrap = (y_q == V_LAST);

    always_ff @(posedge pclk) begin
        if (rst_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (x_wrap) begin
            x_q <= '0;
            if (y_wrap) begin
                y_q <= '0;                          // new frame
            end else begin
                y_q <= y_q + 10'd1;                 // next line
            end
        end else begin
            x_q <= x_q + 10'd1;
        end
    end

    // decode straight off the counters, pixel stage registers the result
    always_comb begin
        raster.x  = x_q;
        raster.y  = y_q;
        raster.de = (x_q < H_ACT) && (y_q < V_ACT);
        raster.hs = (x_q >= HS_START) && (x_q < HS_END);
        raster.vs = (y_q >= VS_START) && (y_q < VS_END);
    end

    assign raster_o = raster;

endmodule

`default_nettype wire

// File: hdl/bus_regs.sv
/*
 * host bus register block: byte writes into the 16-bit control registers,
 * registered byte reads and the output enable level for the data bus
 */
`default_nettype none
`timescale 1ns/1ps

module bus_regs #(
    parameter int V_ACTIVE = 480                    // lines with pixels, for vblank
) (
    input  logic                pclk,
    input  logic                rst_i,              // sync, active high
    input  vid_pkg::bus_t       bus_i,              // host bus levels
    input  vid_pkg::timing_t    raster_i,           // current raster position
    output vid_pkg::ctrl_regs_t regs_o,             // values for pixel stage
    output logic [7:0]          bus_data_o,         // read byte, valid one edge later
    output logic                bus_oe_o            // host may sample bus_data_o
);
    import vid_pkg::*;

    localparam logic [9:0] V_ACT = 10'(V_ACTIVE);

    ctrl_regs_t  regs_q;                            // fg, bg, mode
    logic [15:0] scratch_q;                         // free host register
    logic [15:0] rd_word;                           // addressed register as a word
    logic [7:0]  rd_data_q;                         // byte returned to host
    logic        vblank;                            // below the active lines
    logic        wr_en;
    logic        rd_en;

    assign wr_en  = !bus_i.cs_n && !bus_i.rd_nwr;   // sampled every edge, no strobe
    assign rd_en  = !bus_i.cs_n &&  bus_i.rd_nwr;
    assign vblank = (raster_i.y >= V_ACT);

    // even byte lands in 15:8 and odd byte in 7:0, 68000 order
    always_ff @(posedge pclk) begin
        if (rst_i) begin
            regs_q    <= '{fg: '0, bg: '0, mode: PAT_SOLID};
            scratch_q <= '0;
        end else if (wr_en) begin
            case (bus_i.reg_num)
                REG_FG: begin
                    if (!bus_i.bytesel) begin
                        regs_q.fg.r <= bus_i.data[3:0];             // bits 15:12 not stored
                    end else begin
                        {regs_q.fg.g, regs_q.fg.b} <= bus_i.data;
                    end
                end
                REG_BG: begin
                    if (!bus_i.bytesel) begin
                        regs_q.bg.r <= bus_i.data[3:0];
                    end else begin
                        {regs_q.bg.g, regs_q.bg.b} <= bus_i.data;
                    end
                end
                REG_MODE: begin
                    if (bus_i.bytesel) begin                        // high byte has no bits
                        regs_q.mode <= pat_mode_e'(bus_i.data[1:0]);
                    end
                end
                REG_SCRATCH: begin
                    if (!bus_i.bytesel) begin
                        scratch_q[15:8] <= bus_i.data;
                    end else begin
                        scratch_q[7:0] <= bus_i.data;
                    end
                end
                default: ;                                          // status and spare slots
            endcase
        end
    end

    // word mux for reads, unimplemented bits return zero
    always_comb begin
        case (bus_i.reg_num)
            REG_FG:      rd_word = {4'h0, regs_q.fg};
            REG_BG:      rd_word = {4'h0, regs_q.bg};
            REG_MODE:    rd_word = {14'h0, regs_q.mode};
            REG_SCRATCH: rd_word = scratch_q;
            REG_STATUS:  rd_word = {vblank, 5'h00, raster_i.y};     // live line number
            default:     rd_word = 16'h0000;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (rd_en) begin
            rd_data_q <= bus_i.bytesel ? rd_word[7:0] : rd_word[15:8];
        end
    end

    assign regs_o     = regs_q;
    assign bus_data_o = rd_data_q;
    assign bus_oe_o   = rd_en && !rst_i;                // no drive while core is in reset

endmodule

`default_nettype wire

// File: hdl/vid_pkg.sv
/*
 * shared types for the video controller: host bus, register slots,
 * pattern modes, raster state and video output; imported by RTL and testbench
 */
`default_nettype none

package vid_pkg;

    typedef struct packed {
        logic [3:0] r;                          // red
        logic [3:0] g;                          // green
        logic [3:0] b;                          // blue
    } rgb_t;                                    // 12-bit colour, r in bits 11:8

    typedef enum logic [1:0] {
        PAT_SOLID = 2'd0,                       // fg everywhere
        PAT_BARS  = 2'd1,                       // fg where x[3] set
        PAT_CHECK = 2'd2                        // fg where x[3] != y[3]
    } pat_mode_e;

    typedef enum logic [3:0] {
        REG_FG      = 4'd0,                     // fg colour in bits 11:0
        REG_BG      = 4'd1,                     // bg colour in bits 11:0
        REG_MODE    = 4'd2,                     // pattern mode in bits 1:0
        REG_SCRATCH = 4'd3,                     // free 16 bits for the host
        REG_STATUS  = 4'd4                      // read only, vblank and line
    } reg_num_e;                                // slots 5..15 read zero

    typedef struct packed {
        rgb_t      fg;                          // foreground colour
        rgb_t      bg;                          // background colour
        pat_mode_e mode;                        // pattern select
    } ctrl_regs_t;

    typedef struct packed {
        logic       de;                         // display enable
        logic       hs;                         // hsync, active high
        logic       vs;                         // vsync, active high
        logic [9:0] x;                          // pixel within line
        logic [9:0] y;                          // line within frame
    } timing_t;

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
        rgb_t rgb;                              // black outside de
    } video_t;

    typedef struct packed {
        logic     cs_n;                         // chip select, active low
        logic     rd_nwr;                       // 1 read, 0 write
        logic     bytesel;                      // 0 even byte (15:8), 1 odd (7:0)
        reg_num_e reg_num;                      // register slot
        logic [7:0] data;                       // write data from host
    } bus_t;

endpackage

`default_nettype wire
